// File: rtl/mem_pipe_pkg.sv
package mem_pipe_pkg;

    // data and byte address
    typedef logic [15:0] word_t;

    // register file destination
    typedef logic [2:0] reg_t;

    // operation kind handed down from execute
    typedef enum logic [1:0] {
        op_alu,
        op_ldr,
        op_str
    } mem_op_t;

    typedef logic [2:0] perf_idx_t;

    // counter bank
    localparam int N_PERF = 7;

    // size of the counter window in bytes
    localparam int PERF_WINDOW = 16;

    // counter positions, address bits 3:1 in the window
    localparam perf_idx_t PERF_I_HIT   = 3'd0;
    localparam perf_idx_t PERF_I_MISS  = 3'd1;
    localparam perf_idx_t PERF_D_HIT   = 3'd2;
    localparam perf_idx_t PERF_D_MISS  = 3'd3;
    localparam perf_idx_t PERF_L2_HIT  = 3'd4;
    localparam perf_idx_t PERF_L2_MISS = 3'd5;
    localparam perf_idx_t PERF_STALL   = 3'd6;

endpackage : mem_pipe_pkg

// File: rtl/barrier_ex_mem.sv
module barrier_ex_mem
    import mem_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,

    input  logic    ex_valid,
    input  mem_op_t ex_op,
    input  word_t   ex_alu,
    input  word_t   ex_sr2,
    input  reg_t    ex_dest,

    output logic    mem_valid,
    output mem_op_t mem_op,
    output word_t   mem_alu,
    output word_t   mem_sr2,
    output reg_t    mem_dest
);

// valid bit is the only control state
always_ff @(posedge clk) begin
    if (rst) begin
        mem_valid <= 1'b0;
    end else if (!hold) begin
        mem_valid <= ex_valid;
    end
end

// payload just follows the valid bit
always_ff @(posedge clk) begin
    if (!hold) begin
        mem_op   <= ex_op;
        mem_alu  <= ex_alu;
        mem_sr2  <= ex_sr2;
        mem_dest <= ex_dest;
    end
end

endmodule : barrier_ex_mem

// File: rtl/mem_access_fsm.sv
module mem_access_fsm
    import mem_pipe_pkg::*;
#(
    parameter word_t PERF_BASE = 16'hff00
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      mem_valid,
    input  mem_op_t   mem_op,
    input  word_t     mem_alu,
    input  word_t     mem_sr2,
    input  word_t     perf_data,

    output logic      hold,
    output logic      wb_valid,
    output logic      mdr_sel,
    output word_t     mdr,
    output logic      perf_rd,
    output logic      perf_clr,
    output perf_idx_t perf_idx,

    output logic      dmem_cyc,
    output logic      dmem_stb,
    output logic      dmem_we,
    output word_t     dmem_adr,
    output word_t     dmem_wdata,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata
);

typedef enum logic {
    idle,
    bus_wait
} state_t;

localparam word_t WIN_MASK = ~word_t'(PERF_WINDOW - 1);

state_t state;
logic   is_mem_op;
logic   in_window;
logic   bus_req;

assign is_mem_op = mem_valid && (mem_op == op_ldr || mem_op == op_str);
assign in_window = (mem_alu & WIN_MASK) == PERF_BASE;
assign bus_req   = (state == idle) && is_mem_op && !in_window;

// counter accesses finish in their single MEM cycle
assign perf_rd  = (state == idle) && is_mem_op && in_window && (mem_op == op_ldr);
assign perf_clr = (state == idle) && is_mem_op && in_window && (mem_op == op_str);
assign perf_idx = mem_alu[3:1];

// stall from the first MEM cycle until the ack edge
assign hold     = bus_req || (state == bus_wait && !dmem_ack);
assign wb_valid = (state == idle && mem_valid && !bus_req) ||
                  (state == bus_wait && dmem_ack);

assign mdr_sel = (mem_op == op_ldr);
assign mdr     = perf_rd ? perf_data : dmem_rdata;

// strobes come up one cycle into the stall, so ack can never land early
assign dmem_cyc   = (state == bus_wait);
assign dmem_stb   = (state == bus_wait);
assign dmem_we    = (state == bus_wait) && (mem_op == op_str);
assign dmem_adr   = mem_alu;
assign dmem_wdata = mem_sr2;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= idle;
    end else begin
        case (state)
            idle:     if (bus_req) state <= bus_wait;
            bus_wait: if (dmem_ack) state <= idle;
            default:  state <= idle;
        endcase
    end
end

endmodule : mem_access_fsm

// File: rtl/perf_counters.sv
module perf_counters
    import mem_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      debug_i_cache_hit,
    input  logic      debug_i_cache_miss,
    input  logic      debug_d_cache_hit,
    input  logic      debug_d_cache_miss,
    input  logic      debug_l2_cache_hit,
    input  logic      debug_l2_cache_miss,
    input  logic      stall,

    input  logic      perf_clr,
    input  perf_idx_t perf_idx,
    output word_t     perf_data
);

word_t             cnt [N_PERF];
logic [N_PERF-1:0] ev;

always_comb begin
    ev               = '0;
    ev[PERF_I_HIT]   = debug_i_cache_hit;
    ev[PERF_I_MISS]  = debug_i_cache_miss;
    ev[PERF_D_HIT]   = debug_d_cache_hit;
    ev[PERF_D_MISS]  = debug_d_cache_miss;
    ev[PERF_L2_HIT]  = debug_l2_cache_hit;
    ev[PERF_L2_MISS] = debug_l2_cache_miss;
    ev[PERF_STALL]   = stall;
end

// a clear beats a same-cycle increment
always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < N_PERF; i++) begin
            cnt[i] <= '0;
        end
    end else begin
        for (int i = 0; i < N_PERF; i++) begin
            if (perf_clr && perf_idx == perf_idx_t'(i)) begin
                cnt[i] <= '0;
            end else if (ev[i]) begin
                cnt[i] <= cnt[i] + 16'd1;
            end
        end
    end
end

// index 7 has no counter behind it
always_comb begin
    perf_data = '0;
    for (int i = 0; i < N_PERF; i++) begin
        if (perf_idx == perf_idx_t'(i)) begin
            perf_data = cnt[i];
        end
    end
end

endmodule : perf_counters

// File: rtl/barrier_mem_wb.sv
module barrier_mem_wb
    import mem_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    wb_valid,
    input  mem_op_t mem_op,
    input  reg_t    mem_dest,
    input  word_t   mem_alu,
    input  word_t   mdr,
    input  logic    mdr_sel,

    output reg_t    regfile_dest,
    output word_t   regfile_data,
    output logic    regfile_load
);

logic  load_next;
word_t data_next;

// stores retire without a register write
assign load_next = wb_valid && (mem_op != op_str);
assign data_next = mdr_sel ? mdr : mem_alu;

always_ff @(posedge clk) begin
    if (rst) begin
        regfile_load <= 1'b0;
    end else begin
        regfile_load <= load_next;
    end
end

// dest and data only load when an op completes
always_ff @(posedge clk) begin
    if (wb_valid) begin
        regfile_dest <= mem_dest;
        regfile_data <= data_next;
    end
end

endmodule : barrier_mem_wb

// File: rtl/mem_pipe.sv
module mem_pipe
    import mem_pipe_pkg::*;
#(
    parameter word_t PERF_BASE = 16'hff00
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    ex_valid,
    input  mem_op_t ex_op,
    input  word_t   ex_alu,
    input  word_t   ex_sr2,
    input  reg_t    ex_dest,
    output logic    ex_stall,

    output logic    dmem_cyc,
    output logic    dmem_stb,
    output logic    dmem_we,
    output word_t   dmem_adr,
    output word_t   dmem_wdata,
    input  logic    dmem_ack,
    input  word_t   dmem_rdata,

    input  logic    debug_i_cache_hit,
    input  logic    debug_i_cache_miss,
    input  logic    debug_d_cache_hit,
    input  logic    debug_d_cache_miss,
    input  logic    debug_l2_cache_hit,
    input  logic    debug_l2_cache_miss,

    output reg_t    regfile_dest,
    output word_t   regfile_data,
    output logic    regfile_load
);

logic      mem_valid;
mem_op_t   mem_op;
word_t     mem_alu;
word_t     mem_sr2;
reg_t      mem_dest;

logic      hold;
logic      wb_valid;
logic      mdr_sel;
word_t     mdr;
logic      perf_rd;
logic      perf_clr;
perf_idx_t perf_idx;
word_t     perf_data;

// the access FSM is the only stall source
assign ex_stall = hold;

barrier_ex_mem _barrier_ex_mem (
    .clk, .rst, .hold,
    .ex_valid, .ex_op, .ex_alu, .ex_sr2, .ex_dest,
    .mem_valid, .mem_op, .mem_alu, .mem_sr2, .mem_dest
);

mem_access_fsm #(.PERF_BASE(PERF_BASE)) _mem_access_fsm (
    .clk, .rst,
    .mem_valid, .mem_op, .mem_alu, .mem_sr2, .perf_data,
    .hold, .wb_valid, .mdr_sel, .mdr, .perf_rd, .perf_clr, .perf_idx,
    .dmem_cyc, .dmem_stb, .dmem_we, .dmem_adr, .dmem_wdata, .dmem_ack, .dmem_rdata
);

perf_counters _perf_counters (
    .clk, .rst,
    .debug_i_cache_hit, .debug_i_cache_miss,
    .debug_d_cache_hit, .debug_d_cache_miss,
    .debug_l2_cache_hit, .debug_l2_cache_miss,
    .stall(hold),
    .perf_clr, .perf_idx, .perf_data
);

barrier_mem_wb _barrier_mem_wb (
    .clk, .rst,
    .wb_valid, .mem_op, .mem_dest, .mem_alu, .mdr, .mdr_sel,
    .regfile_dest, .regfile_data, .regfile_load
);

endmodule : mem_pipe

// File: sim/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

initial begin
    clk = 1'b0;
    forever begin
        #(PERIOD / 2) clk = ~clk;
    end
end

endmodule : tb_clock

// File: sim/mem_pipe_chk.sv
module mem_pipe_chk
    import mem_pipe_pkg::*;
#(
    parameter word_t PERF_BASE = 16'hff00
) (
    input logic    clk,
    input logic    rst,
    input logic    ex_valid,
    input mem_op_t ex_op,
    input word_t   ex_alu,
    input word_t   ex_sr2,
    input reg_t    ex_dest,
    input logic    ex_stall,
    input logic    dmem_cyc,
    input logic    dmem_stb,
    input logic    dmem_we,
    input word_t   dmem_adr,
    input word_t   dmem_wdata,
    input logic    dmem_ack,
    input logic    debug_d_cache_hit,
    input reg_t    regfile_dest,
    input word_t   regfile_data,
    input logic    regfile_load
);

int fail_count = 0;

// model of the op in MEM
logic      seen;
logic      m_valid;
mem_op_t   m_op;
word_t     m_alu;
word_t     m_sr2;
reg_t      m_dest;
logic      win;
logic      done;
perf_idx_t idx;

// shadow counts since the last clear
word_t dhit_cnt;
word_t stall_cnt;

// expected writeback one cycle after completion
logic  wb_v;
logic  wb_chk;
word_t wb_x;
reg_t  wb_d;

assign win  = m_alu >= PERF_BASE && m_alu <= PERF_BASE + 16'd15;
assign idx  = m_alu[3:1];
assign done = m_valid && (m_op == op_alu || win || (dmem_stb && dmem_ack));

always_ff @(posedge clk) begin
    if (rst) begin
        seen      <= 1'b0;
        m_valid   <= 1'b0;
        dhit_cnt  <= '0;
        stall_cnt <= '0;
        wb_v      <= 1'b0;
    end else begin
        if (ex_valid && !ex_stall) begin
            seen <= 1'b1;
        end
        if (!ex_stall) begin
            m_valid <= ex_valid;
            m_op    <= ex_op;
            m_alu   <= ex_alu;
            m_sr2   <= ex_sr2;
            m_dest  <= ex_dest;
        end
        if (m_valid && win && m_op == op_str && idx == 3'd2) begin
            dhit_cnt <= '0;
        end else if (debug_d_cache_hit) begin
            dhit_cnt <= dhit_cnt + 16'd1;
        end
        if (m_valid && win && m_op == op_str && idx == 3'd6) begin
            stall_cnt <= '0;
        end else if (ex_stall) begin
            stall_cnt <= stall_cnt + 16'd1;
        end
        wb_v   <= done && m_op != op_str;
        wb_d   <= m_dest;
        wb_chk <= 1'b1;
        if (m_op == op_alu) begin
            wb_x <= m_alu;
        end else if (!win) begin
            wb_x <= ~m_alu;
        end else if (idx == 3'd2) begin
            wb_x <= dhit_cnt;
        end else if (idx == 3'd6) begin
            wb_x <= stall_cnt;
        end else if (idx == 3'd7) begin
            wb_x <= '0;
        end else begin
            wb_chk <= 1'b0;
        end
    end
end

a_reset: assert property (@(posedge clk) disable iff (rst)
    !seen |-> !ex_stall && !dmem_cyc && !dmem_stb && !regfile_load)
    else begin
        fail_count++;
        $error("outputs became active before any operation was accepted");
    end

a_load: assert property (@(posedge clk) disable iff (rst) wb_v |-> regfile_load)
    else begin
        fail_count++;
        $error("error %0t regfile_load got %b expected 1", $time, regfile_load);
    end

a_noload: assert property (@(posedge clk) disable iff (rst) !wb_v |-> !regfile_load)
    else begin
        fail_count++;
        $error("error %0t regfile_load got %b expected 0", $time, regfile_load);
    end

a_data: assert property (@(posedge clk) disable iff (rst)
    wb_v && wb_chk |-> regfile_data == wb_x)
    else begin
        fail_count++;
        $error("error %0t regfile_data got %h expected %h", $time, regfile_data, wb_x);
    end

a_dest: assert property (@(posedge clk) disable iff (rst) wb_v |-> regfile_dest == wb_d)
    else begin
        fail_count++;
        $error("error %0t regfile_dest got %0d expected %0d", $time, regfile_dest, wb_d);
    end

a_cyc: assert property (@(posedge clk) disable iff (rst) dmem_stb |-> dmem_cyc)
    else begin
        fail_count++;
        $error("dmem_stb was high without dmem_cyc");
    end

a_stall: assert property (@(posedge clk) disable iff (rst) dmem_stb && !dmem_ack |-> ex_stall)
    else begin
        fail_count++;
        $error("ex_stall was low while a bus cycle waited for ack");
    end

// expected values are held during a stall and so also cover stability
a_adr: assert property (@(posedge clk) disable iff (rst) dmem_stb |-> dmem_adr == m_alu)
    else begin
        fail_count++;
        $error("error %0t dmem_adr got %h expected %h", $time, dmem_adr, m_alu);
    end

a_we: assert property (@(posedge clk) disable iff (rst)
    dmem_stb |-> dmem_we == (m_op == op_str))
    else begin
        fail_count++;
        $error("error %0t dmem_we got %b expected %b", $time, dmem_we, m_op == op_str);
    end

a_wdata: assert property (@(posedge clk) disable iff (rst)
    dmem_stb && dmem_we |-> dmem_wdata == m_sr2)
    else begin
        fail_count++;
        $error("error %0t dmem_wdata got %h expected %h", $time, dmem_wdata, m_sr2);
    end

a_window: assert property (@(posedge clk) disable iff (rst)
    m_valid && win |-> !ex_stall ##1 !dmem_stb)
    else begin
        fail_count++;
        $error("a counter window access stalled or started a bus cycle");
    end

endmodule : mem_pipe_chk

bind mem_pipe mem_pipe_chk #(.PERF_BASE(PERF_BASE)) chk (.*);

// File: sim/mem_pipe_tb.sv
// acks after 0 to 3 extra cycles, read data is the inverted address
module bus_memory
    import mem_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  dmem_stb,
    input  word_t dmem_adr,
    output logic  dmem_ack,
    output word_t dmem_rdata
);

logic       busy;
logic [1:0] left;
logic [1:0] delay;

assign delay      = dmem_adr[9:8] ^ dmem_adr[2:1];
assign dmem_rdata = ~dmem_adr;

initial begin
    dmem_ack = 1'b0;
    busy     = 1'b0;
end

always @(negedge clk) begin
    if (rst || !dmem_stb) begin
        dmem_ack <= 1'b0;
        busy     <= 1'b0;
    end else if (!busy) begin
        busy     <= 1'b1;
        left     <= delay;
        dmem_ack <= (delay == 2'd0);
    end else if (!dmem_ack) begin
        left     <= left - 2'd1;
        dmem_ack <= (left == 2'd1);
    end
end

endmodule : bus_memory

module mem_pipe_tb;
    import mem_pipe_pkg::*;

logic    clk;
logic    rst;
logic    ex_valid;
mem_op_t ex_op;
word_t   ex_alu;
word_t   ex_sr2;
reg_t    ex_dest;
logic    ex_stall;
logic    dmem_cyc;
logic    dmem_stb;
logic    dmem_we;
word_t   dmem_adr;
word_t   dmem_wdata;
logic    dmem_ack;
word_t   dmem_rdata;
logic    debug_i_cache_hit;
logic    debug_i_cache_miss;
logic    debug_d_cache_hit;
logic    debug_d_cache_miss;
logic    debug_l2_cache_hit;
logic    debug_l2_cache_miss;
reg_t    regfile_dest;
word_t   regfile_data;
logic    regfile_load;

logic [31:0] op_seed = 32'hcb8b1df6;
logic [31:0] strobe_seed = 32'hcb8b1df6;
int          timeouts = 0;
int          tests = 0;
int          base = 0;

tb_clock #(.PERIOD(8)) clock_gen (.clk);
mem_pipe dut (.*);
bus_memory mem (.clk, .rst, .dmem_stb, .dmem_adr, .dmem_ack, .dmem_rdata);

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic word_t next_word();
    op_seed = lcg_step(op_seed);
    return op_seed[31:16];
endfunction

// random address kept out of the counter window
function automatic word_t bus_addr();
    word_t w;
    w = next_word();
    if ((w & 16'hfff0) == 16'hff00) begin
        w[8] = ~w[8];
    end
    return w;
endfunction

function automatic word_t window_addr(input perf_idx_t idx);
    return 16'hff00 | {12'h0, idx, 1'b0};
endfunction

// event strobes change on every falling edge
always @(negedge clk) begin
    strobe_seed = lcg_step(strobe_seed);
    {debug_i_cache_hit, debug_i_cache_miss, debug_d_cache_hit,
     debug_d_cache_miss, debug_l2_cache_hit, debug_l2_cache_miss} = strobe_seed[21:16];
end

// called on a falling edge, returns on the falling edge after acceptance
task automatic send(input mem_op_t op, input word_t alu, input word_t sr2);
    word_t w;
    int    n;
    bit    ok;
    w        = next_word();
    ex_valid = 1'b1;
    ex_op    = op;
    ex_alu   = alu;
    ex_sr2   = sr2;
    ex_dest  = w[2:0];
    n        = 0;
    ok       = 1'b0;
    while (!ok && n < 50) begin
        @(posedge clk);
        ok = !ex_stall;
        n++;
        @(negedge clk);
    end
    ex_valid = 1'b0;
    if (!ok) begin
        timeouts++;
        $display("timeout: operation was never accepted at %0t", $time);
    end
endtask

task automatic end_test(input string name);
    int n;
    n = 0;
    while (ex_stall && n < 50) begin
        @(negedge clk);
        n++;
    end
    if (ex_stall) begin
        timeouts++;
        $display("timeout: stall never cleared in test %s", name);
    end
    repeat (3) @(negedge clk);
    tests++;
    $display("test %s: %0d assertion failures", name, dut.chk.fail_count - base);
    base = dut.chk.fail_count;
endtask

initial begin
    word_t w;
    rst      = 1'b1;
    ex_valid = 1'b0;
    ex_op    = op_alu;
    ex_alu   = '0;
    ex_sr2   = '0;
    ex_dest  = '0;
    {debug_i_cache_hit, debug_i_cache_miss, debug_d_cache_hit,
     debug_d_cache_miss, debug_l2_cache_hit, debug_l2_cache_miss} = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (5) @(negedge clk);
    end_test("reset");

    repeat (20) send(op_alu, next_word(), next_word());
    end_test("alu back to back");

    repeat (8) send(op_str, bus_addr(), next_word());
    end_test("bus stores");

    repeat (10) begin
        send(op_ldr, bus_addr(), next_word());
        send(op_alu, next_word(), next_word());
    end
    end_test("bus loads");

    repeat (12) begin
        w = next_word();
        send(op_ldr, window_addr(w[2:0]), '0);
        send(op_ldr, bus_addr(), '0);
    end
    end_test("counter reads");

    send(op_str, window_addr(PERF_D_HIT), '0);
    send(op_str, window_addr(PERF_STALL), '0);
    repeat (4) send(op_str, bus_addr(), next_word());
    send(op_ldr, window_addr(PERF_D_HIT), '0);
    send(op_ldr, window_addr(PERF_STALL), '0);
    end_test("counter clear");

    $display("tests %0d, assertion failures %0d, timeouts %0d",
             tests, dut.chk.fail_count, timeouts);
    if (dut.chk.fail_count == 0 && timeouts == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

endmodule : mem_pipe_tb

// File: mem_pipe.f
rtl/mem_pipe_pkg.sv
rtl/barrier_ex_mem.sv
rtl/mem_access_fsm.sv
rtl/perf_counters.sv
rtl/barrier_mem_wb.sv
rtl/mem_pipe.sv
sim/tb_clock.sv
sim/mem_pipe_chk.sv
sim/mem_pipe_tb.sv

// File: Bender.yml
package:
  name: mem_pipe

sources:
  - files:
      - rtl/mem_pipe_pkg.sv
      - rtl/barrier_ex_mem.sv
      - rtl/mem_access_fsm.sv
      - rtl/perf_counters.sv
      - rtl/barrier_mem_wb.sv
      - rtl/mem_pipe.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/mem_pipe_chk.sv
      - sim/mem_pipe_tb.sv
